// File: bp_pkg.sv
`default_nettype none

package bp_pkg;

    // address and instruction word width
    localparam int xlen = 32;

    // table geometry, used as top level parameter defaults
    localparam int num_banks     = 4;
    localparam int rows_per_bank = 8;

    // bank bits + row bits
    localparam int idx_bits = $clog2(num_banks) + $clog2(rows_per_bank);

    // global history spans the whole index
    localparam int hist_bits = idx_bits;

    // pc without the two low bits
    localparam int tag_bits = xlen - 2;

    // kind of resolved control transfer
    typedef enum logic [1:0] {
        kind_cond = 2'd0,
        kind_jal  = 2'd1,
        kind_jalr = 2'd2
    } upd_kind_t;

    // 2-bit saturating counter
    typedef logic [1:0] ctr_t;

    // saturation limits
    localparam ctr_t ctr_strong_not_taken = 2'd0;
    localparam ctr_t ctr_strong_taken     = 2'd3;

    // allocation values, also the taken threshold
    localparam ctr_t ctr_weak_not_taken = 2'd1;
    localparam ctr_t ctr_weak_taken     = 2'd2;

endpackage

`default_nettype wire

// File: bp_index_router.sv
`timescale 1ns/100ps
`default_nettype none

module bp_index_router #(
    parameter int  NUM_BANKS     = bp_pkg::num_banks,
    parameter int  ROWS_PER_BANK = bp_pkg::rows_per_bank,
    localparam int BANK_BITS     = $clog2(NUM_BANKS),
    localparam int ROW_BITS      = $clog2(ROWS_PER_BANK)
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [bp_pkg::xlen-1:0]       pc,
    input  logic                          upd_req,
    input  logic [bp_pkg::xlen-1:0]       upd_pc,
    input  bp_pkg::upd_kind_t             upd_kind,
    input  logic                          upd_taken,
    input  logic [bp_pkg::xlen-1:0]       upd_target,
    input  logic [bp_pkg::hist_bits-1:0]  upd_history,
    input  logic [NUM_BANKS-1:0]          bank_ack,
    output logic                          upd_ack,
    output logic [ROW_BITS-1:0]           lookup_row,
    output logic [bp_pkg::tag_bits-1:0]   lookup_tag,
    output logic [BANK_BITS-1:0]          lookup_bank,
    output logic [bp_pkg::hist_bits-1:0]  lookup_history,
    output logic [NUM_BANKS-1:0]          bank_req,
    output logic [ROW_BITS-1:0]           upd_row,
    output logic [bp_pkg::tag_bits-1:0]   upd_tag,
    output logic                          upd_taken_eff,
    output logic [bp_pkg::xlen-1:0]       upd_target_out
);
    import bp_pkg::*;

    logic [hist_bits-1:0] hist_q;
    logic [hist_bits-1:0] lookup_idx;
    logic [hist_bits-1:0] upd_idx;
    logic                 req_q;
    logic                 ack_seen_q;
    logic [BANK_BITS-1:0] bank_sel_q;
    logic                 taken_eff;
    logic                 capture;

    // gshare hash for the fetch side
    assign lookup_idx     = pc[2 +: hist_bits] ^ hist_q;
    // low bits pick the bank, the rest the row
    assign lookup_bank    = lookup_idx[BANK_BITS-1:0];
    assign lookup_row     = lookup_idx[BANK_BITS +: ROW_BITS];
    assign lookup_tag     = pc[xlen-1:2];
    assign lookup_history = hist_q;

    // update side hashes with the history it was predicted under
    assign upd_idx = upd_pc[2 +: hist_bits] ^ upd_history;

    // jumps always count as taken
    assign taken_eff = (upd_kind == kind_cond) ? upd_taken : 1'b1;

    // rising edge of the registered request
    assign capture = upd_req && !req_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q      <= 1'b0;
            bank_sel_q <= '0;
        end else begin
            req_q <= upd_req;
            if (capture) begin
                bank_sel_q <= upd_idx[BANK_BITS-1:0];
            end
        end
    end

    // fields may change once ack is up, so hold a copy for the bank
    always_ff @(posedge clk) begin
        if (capture) begin
            upd_row        <= upd_idx[BANK_BITS +: ROW_BITS];
            upd_tag        <= upd_pc[xlen-1:2];
            upd_taken_eff  <= taken_eff;
            upd_target_out <= upd_target;
        end
    end

    // only the addressed bank sees the request
    always_comb begin
        bank_req             = '0;
        bank_req[bank_sel_q] = req_q;
    end

    // ack comes straight back from that bank
    assign upd_ack = bank_ack[bank_sel_q];

    // history shifts once per update, at the first ack cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            hist_q     <= '0;
            ack_seen_q <= 1'b0;
        end else begin
            ack_seen_q <= upd_ack;
            if (upd_ack && !ack_seen_q) begin
                hist_q <= {hist_q[hist_bits-2:0], upd_taken_eff};
            end
        end
    end

endmodule

`default_nettype wire

// File: bp_bank.sv
`timescale 1ns/100ps
`default_nettype none

module bp_bank #(
    parameter int  ROWS_PER_BANK = bp_pkg::rows_per_bank,
    localparam int ROW_BITS      = $clog2(ROWS_PER_BANK)
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [ROW_BITS-1:0]          lookup_row,
    input  logic [bp_pkg::tag_bits-1:0]  lookup_tag,
    input  logic                         bank_req,
    input  logic [ROW_BITS-1:0]          upd_row,
    input  logic [bp_pkg::tag_bits-1:0]  upd_tag,
    input  logic                         upd_taken_eff,
    input  logic [bp_pkg::xlen-1:0]      upd_target,
    output logic                         lookup_hit,
    output logic                         lookup_strong,
    output logic [bp_pkg::xlen-1:0]      lookup_target,
    output logic                         bank_ack
);
    import bp_pkg::*;

    logic [ROWS_PER_BANK-1:0] valid_q;
    logic [tag_bits-1:0]      tag_q    [ROWS_PER_BANK];
    logic [xlen-1:0]          target_q [ROWS_PER_BANK];
    ctr_t                     ctr_q    [ROWS_PER_BANK];
    logic                     upd_match;
    logic                     do_write;
    ctr_t                     ctr_next;

    // read port, no clock
    assign lookup_hit    = valid_q[lookup_row] && (tag_q[lookup_row] == lookup_tag);
    assign lookup_strong = ctr_q[lookup_row] >= ctr_weak_taken;
    assign lookup_target = target_q[lookup_row];

    // existing entry for this branch?
    assign upd_match = valid_q[upd_row] && (tag_q[upd_row] == upd_tag);

    // write once per request, before ack is up
    assign do_write = bank_req && !bank_ack;

    always_comb begin
        if (!upd_match) begin
            // fresh entry starts weak
            ctr_next = upd_taken_eff ? ctr_weak_taken : ctr_weak_not_taken;
        end else if (upd_taken_eff) begin
            // count up, stop at 3
            ctr_next = (ctr_q[upd_row] == ctr_strong_taken) ? ctr_strong_taken
                                                             : ctr_q[upd_row] + 2'd1;
        end else begin
            // count down, stop at 0
            ctr_next = (ctr_q[upd_row] == ctr_strong_not_taken) ? ctr_strong_not_taken
                                                                 : ctr_q[upd_row] - 2'd1;
        end
    end

    // ack follows req, one cycle behind
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q  <= '0;
            bank_ack <= 1'b0;
        end else begin
            bank_ack <= bank_req;
            if (do_write) begin
                valid_q[upd_row] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            // tag is unchanged on a match anyway
            tag_q[upd_row] <= upd_tag;
            ctr_q[upd_row] <= ctr_next;
            // keep old target on a not-taken refresh
            if (!upd_match || upd_taken_eff) begin
                target_q[upd_row] <= upd_target;
            end
        end
    end

endmodule

`default_nettype wire

// File: bp_pred_select.sv
`timescale 1ns/100ps
`default_nettype none

module bp_pred_select #(
    parameter int  NUM_BANKS = bp_pkg::num_banks,
    localparam int BANK_BITS = $clog2(NUM_BANKS)
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [bp_pkg::xlen-1:0]               pc,
    input  logic [BANK_BITS-1:0]                  lookup_bank,
    input  logic [bp_pkg::hist_bits-1:0]          lookup_history,
    input  logic [NUM_BANKS-1:0]                  lookup_hit,
    input  logic [NUM_BANKS-1:0]                  lookup_strong,
    input  logic [NUM_BANKS-1:0][bp_pkg::xlen-1:0] lookup_target,
    output logic [bp_pkg::xlen-1:0]               pred_pc,
    output logic                                  pred_taken,
    output logic                                  pred_hit,
    output logic [bp_pkg::hist_bits-1:0]          pred_history
);
    import bp_pkg::*;

    logic            sel_hit;
    logic            sel_taken;
    logic [xlen-1:0] next_pc;

    // answer from the addressed bank only
    assign sel_hit   = lookup_hit[lookup_bank];
    assign sel_taken = sel_hit && lookup_strong[lookup_bank];

    // target when leaning taken, else fall through
    assign next_pc = sel_taken ? lookup_target[lookup_bank] : pc + xlen'(4);

    always_ff @(posedge clk) begin
        if (reset) begin
            pred_hit     <= 1'b0;
            pred_taken   <= 1'b0;
            pred_history <= '0;
        end else begin
            pred_hit     <= sel_hit;
            pred_taken   <= sel_taken;
            pred_history <= lookup_history;
        end
    end

    // address payload
    always_ff @(posedge clk) begin
        pred_pc <= next_pc;
    end

endmodule

`default_nettype wire

// File: branch_predictor.sv
`timescale 1ns/100ps
`default_nettype none

module branch_predictor #(
    parameter int  NUM_BANKS     = bp_pkg::num_banks,
    parameter int  ROWS_PER_BANK = bp_pkg::rows_per_bank,
    localparam int BANK_BITS     = $clog2(NUM_BANKS),
    localparam int ROW_BITS      = $clog2(ROWS_PER_BANK)
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [bp_pkg::xlen-1:0]       pc,
    input  logic                          upd_req,
    input  logic [bp_pkg::xlen-1:0]       upd_pc,
    input  bp_pkg::upd_kind_t             upd_kind,
    input  logic                          upd_taken,
    input  logic [bp_pkg::xlen-1:0]       upd_target,
    input  logic [bp_pkg::hist_bits-1:0]  upd_history,
    output logic [bp_pkg::xlen-1:0]       pred_pc,
    output logic                          pred_taken,
    output logic                          pred_hit,
    output logic [bp_pkg::hist_bits-1:0]  pred_history,
    output logic                          upd_ack
);
    import bp_pkg::*;

    // router to banks, lookup side
    logic [ROW_BITS-1:0]  lookup_row;
    logic [tag_bits-1:0]  lookup_tag;
    // router to selector
    logic [BANK_BITS-1:0] lookup_bank;
    logic [hist_bits-1:0] lookup_history;
    // router to banks, update side
    logic [NUM_BANKS-1:0] bank_req;
    logic [NUM_BANKS-1:0] bank_ack;
    logic [ROW_BITS-1:0]  upd_row;
    logic [tag_bits-1:0]  upd_tag;
    logic                 upd_taken_eff;
    logic [xlen-1:0]      bank_upd_target;
    // banks to selector
    logic [NUM_BANKS-1:0]           lookup_hit;
    logic [NUM_BANKS-1:0]           lookup_strong;
    logic [NUM_BANKS-1:0][xlen-1:0] lookup_target;

    bp_index_router #(
        .NUM_BANKS     (NUM_BANKS),
        .ROWS_PER_BANK (ROWS_PER_BANK)
    ) router_inst (
        .clk            (clk),
        .reset          (reset),
        .pc             (pc),
        .upd_req        (upd_req),
        .upd_pc         (upd_pc),
        .upd_kind       (upd_kind),
        .upd_taken      (upd_taken),
        .upd_target     (upd_target),
        .upd_history    (upd_history),
        .bank_ack       (bank_ack),
        .upd_ack        (upd_ack),
        .lookup_row     (lookup_row),
        .lookup_tag     (lookup_tag),
        .lookup_bank    (lookup_bank),
        .lookup_history (lookup_history),
        .bank_req       (bank_req),
        .upd_row        (upd_row),
        .upd_tag        (upd_tag),
        .upd_taken_eff  (upd_taken_eff),
        .upd_target_out (bank_upd_target)
    );

    // one bank per low index value
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        bp_bank #(
            .ROWS_PER_BANK (ROWS_PER_BANK)
        ) bank_inst (
            .clk           (clk),
            .reset         (reset),
            .lookup_row    (lookup_row),
            .lookup_tag    (lookup_tag),
            .bank_req      (bank_req[b]),
            .upd_row       (upd_row),
            .upd_tag       (upd_tag),
            .upd_taken_eff (upd_taken_eff),
            .upd_target    (bank_upd_target),
            .lookup_hit    (lookup_hit[b]),
            .lookup_strong (lookup_strong[b]),
            .lookup_target (lookup_target[b]),
            .bank_ack      (bank_ack[b])
        );
    end

    bp_pred_select #(
        .NUM_BANKS (NUM_BANKS)
    ) select_inst (
        .clk            (clk),
        .reset          (reset),
        .pc             (pc),
        .lookup_bank    (lookup_bank),
        .lookup_history (lookup_history),
        .lookup_hit     (lookup_hit),
        .lookup_strong  (lookup_strong),
        .lookup_target  (lookup_target),
        .pred_pc        (pred_pc),
        .pred_taken     (pred_taken),
        .pred_hit       (pred_hit),
        .pred_history   (pred_history)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // synchronous reset, released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: branch_predictor_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module branch_predictor_asserts (
    input logic                          clk,
    input logic                          reset,
    input logic                          upd_req,
    input logic                          upd_ack,
    input logic [bp_pkg::xlen-1:0]       upd_pc,
    input bp_pkg::upd_kind_t             upd_kind,
    input logic                          upd_taken,
    input logic [bp_pkg::xlen-1:0]       upd_target,
    input logic [bp_pkg::hist_bits-1:0]  upd_history
);

    // sticky flag, watched by the testbench
    logic assert_failed;

    initial assert_failed = 1'b0;

    // phase 2 only answers a live request
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(upd_ack) |-> upd_req)
        else begin
            $error("upd_ack rose while upd_req was low");
            assert_failed = 1'b1;
        end

    // requester holds the fields until ack
    fields_stable: assert property (@(posedge clk) disable iff (reset)
        (upd_req && !upd_ack) |=> $stable({upd_pc, upd_kind, upd_taken, upd_target, upd_history}))
        else begin
            $error("update fields changed before upd_ack");
            assert_failed = 1'b1;
        end

    // ack stays up until req is gone
    ack_holds: assert property (@(posedge clk) disable iff (reset)
        (upd_ack && upd_req) |=> upd_ack)
        else begin
            $error("upd_ack fell while upd_req was high");
            assert_failed = 1'b1;
        end

    // next request waits for phase 4
    req_after_ack_low: assert property (@(posedge clk) disable iff (reset)
        $rose(upd_req) |-> !upd_ack)
        else begin
            $error("upd_req rose while upd_ack was high");
            assert_failed = 1'b1;
        end

    ack_low_in_reset: assert property (@(posedge clk) reset |=> !upd_ack)
        else begin
            $error("upd_ack high after reset");
            assert_failed = 1'b1;
        end

endmodule

`default_nettype wire

// File: branch_predictor_tb.sv
`timescale 1ns/100ps
`default_nettype none

module branch_predictor_tb;
    import bp_pkg::*;

    localparam int clk_period_ns = 40;
    localparam int entries       = 1 << hist_bits;
    localparam int num_random    = 48;
    localparam int pool_size     = 12;
    localparam int ack_limit     = 8;
    // index bits all zero, so under history 0 it only ever uses entry 0
    localparam logic [xlen-1:0] steer_pc = 32'h0000_0f80;
    // about 8 cycles per update, 3 per lookup, plus idle gaps
    localparam int test_cycles = (40 + 2 * num_random) * 8 + (20 + 2 * num_random) * 3;
    localparam int watchdog_ns = (test_cycles + 500) * clk_period_ns;

    logic                 clk;
    logic                 reset;
    logic [xlen-1:0]      pc;
    logic                 upd_req;
    logic [xlen-1:0]      upd_pc;
    upd_kind_t            upd_kind;
    logic                 upd_taken;
    logic [xlen-1:0]      upd_target;
    logic [hist_bits-1:0] upd_history;
    logic [xlen-1:0]      pred_pc;
    logic                 pred_taken;
    logic                 pred_hit;
    logic [hist_bits-1:0] pred_history;
    logic                 upd_ack;

    // reference model, flat over bank and row
    logic                 model_valid  [entries];
    logic [tag_bits-1:0]  model_tag    [entries];
    logic [xlen-1:0]      model_target [entries];
    ctr_t                 model_ctr    [entries];
    logic [hist_bits-1:0] model_hist;
    logic [xlen-1:0]      pool         [pool_size];

    tb_clock_gen #(
        .PERIOD_NS    (clk_period_ns),
        .RESET_CYCLES (4)
    ) clock_inst (
        .clk   (clk),
        .reset (reset)
    );

    branch_predictor #(
        .NUM_BANKS     (num_banks),
        .ROWS_PER_BANK (rows_per_bank)
    ) branch_predictor_inst (
        .clk          (clk),
        .reset        (reset),
        .pc           (pc),
        .upd_req      (upd_req),
        .upd_pc       (upd_pc),
        .upd_kind     (upd_kind),
        .upd_taken    (upd_taken),
        .upd_target   (upd_target),
        .upd_history  (upd_history),
        .pred_pc      (pred_pc),
        .pred_taken   (pred_taken),
        .pred_hit     (pred_hit),
        .pred_history (pred_history),
        .upd_ack      (upd_ack)
    );

    bind branch_predictor branch_predictor_asserts asserts_inst (
        .clk         (clk),
        .reset       (reset),
        .upd_req     (upd_req),
        .upd_ack     (upd_ack),
        .upd_pc      (upd_pc),
        .upd_kind    (upd_kind),
        .upd_taken   (upd_taken),
        .upd_target  (upd_target),
        .upd_history (upd_history)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] exp);
        assert (got === exp)
        else report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
    endtask

    // jumps count as taken whatever upd_taken says
    function automatic logic effective_taken(input upd_kind_t kind, input logic taken);
        return (kind == kind_cond) ? taken : 1'b1;
    endfunction

    function automatic logic [hist_bits-1:0] next_history(input upd_kind_t kind,
                                                          input logic taken);
        return {model_hist[hist_bits-2:0], effective_taken(kind, taken)};
    endfunction

    task automatic model_update(input logic [xlen-1:0] p, input upd_kind_t kind,
                                input logic taken, input logic [xlen-1:0] target,
                                input logic [hist_bits-1:0] hist);
        logic [hist_bits-1:0] idx;
        logic                 eff;
        eff = effective_taken(kind, taken);
        idx = p[2 +: hist_bits] ^ hist;
        if (!model_valid[idx] || model_tag[idx] != p[xlen-1:2]) begin
            // allocate, weak in the resolved direction
            model_valid[idx]  = 1'b1;
            model_tag[idx]    = p[xlen-1:2];
            model_target[idx] = target;
            model_ctr[idx]    = eff ? ctr_weak_taken : ctr_weak_not_taken;
        end else begin
            if (eff && model_ctr[idx] != 2'd3) begin
                model_ctr[idx] = model_ctr[idx] + 2'd1;
            end else if (!eff && model_ctr[idx] != 2'd0) begin
                model_ctr[idx] = model_ctr[idx] - 2'd1;
            end
            if (eff) begin
                model_target[idx] = target;
            end
        end
        model_hist = {model_hist[hist_bits-2:0], eff};
    endtask

    // all four phases; starts and ends just after a falling edge
    task automatic do_update(input logic [xlen-1:0] p, input upd_kind_t kind,
                             input logic taken, input logic [xlen-1:0] target,
                             input logic [hist_bits-1:0] hist);
        int waited;
        check_val("upd_ack", upd_ack, 0);
        @(posedge clk);
        upd_pc      <= p;
        upd_kind    <= kind;
        upd_taken   <= taken;
        upd_target  <= target;
        upd_history <= hist;
        upd_req     <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ack_limit) report_failure("upd_ack did not rise after upd_req");
        end while (!upd_ack);
        model_update(p, kind, taken, target, hist);
        @(posedge clk);
        upd_req <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ack_limit) report_failure("upd_ack did not fall after upd_req fell");
        end while (upd_ack);
    endtask

    // drive pc, check the registered prediction one edge later
    task automatic do_lookup(input logic [xlen-1:0] p);
        logic [hist_bits-1:0] idx;
        logic                 exp_hit;
        logic                 exp_taken;
        @(posedge clk);
        pc <= p;
        @(posedge clk);
        @(negedge clk);
        idx       = p[2 +: hist_bits] ^ model_hist;
        exp_hit   = model_valid[idx] && (model_tag[idx] == p[xlen-1:2]);
        exp_taken = exp_hit && (model_ctr[idx] >= ctr_weak_taken);
        check_val("pred_hit", pred_hit, exp_hit);
        check_val("pred_taken", pred_taken, exp_taken);
        check_val("pred_pc", pred_pc, exp_taken ? model_target[idx] : p + 32'd4);
        check_val("pred_history", pred_history, model_hist);
    endtask

    // shift a chosen value into the history, msb first
    task automatic steer_history(input logic [hist_bits-1:0] h);
        for (int i = hist_bits - 1; i >= 0; i--) begin
            do_update(steer_pc, kind_cond, h[i], 32'h0000_0100, '0);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            check_val("upd_ack", upd_ack, 0);
        end
    endtask

    task automatic reset_state_misses();
        foreach (pool[i]) begin
            do_lookup(pool[i]);
            check_val("pred_hit", pred_hit, 0);
            check_val("pred_history", pred_history, 0);
        end
    endtask

    task automatic jal_allocates();
        logic [hist_bits-1:0] h;
        // history the lookup will run under
        h = next_history(kind_jal, 1'b0);
        do_update(32'h0000_1a24, kind_jal, 1'b0, 32'h0000_8000, h);
        do_lookup(32'h0000_1a24);
        check_val("pred_taken", pred_taken, 1);
        check_val("pred_pc", pred_pc, 32'h0000_8000);
        check_val("pred_history", pred_history, h);
    endtask

    task automatic counter_hysteresis();
        logic [xlen-1:0]      p;
        logic [hist_bits-1:0] h;
        p = 32'h0000_2c48;
        h = 5'b00110;
        // 2 -> 3 -> 2, still taken
        do_update(p, kind_cond, 1'b1, 32'h0000_9000, h);
        do_update(p, kind_cond, 1'b1, 32'h0000_9000, h);
        do_update(p, kind_cond, 1'b0, 32'h0000_9000, h);
        steer_history(h);
        do_lookup(p);
        check_val("pred_taken", pred_taken, 1);
        check_val("pred_pc", pred_pc, 32'h0000_9000);
        // 2 -> 1 -> 0, falls through but still hits
        do_update(p, kind_cond, 1'b0, 32'h0000_9000, h);
        do_update(p, kind_cond, 1'b0, 32'h0000_9000, h);
        steer_history(h);
        do_lookup(p);
        check_val("pred_hit", pred_hit, 1);
        check_val("pred_taken", pred_taken, 0);
        check_val("pred_pc", pred_pc, p + 32'd4);
    endtask

    task automatic tag_conflict_replaces();
        logic [xlen-1:0]      pa;
        logic [xlen-1:0]      pb;
        logic [hist_bits-1:0] h;
        pa = 32'h0000_3e14;
        // differs above the index bits only
        pb = pa ^ 32'h0004_0000;
        h  = 5'b10011;
        do_update(pa, kind_jal, 1'b1, 32'h0000_a000, h);
        steer_history(h);
        do_lookup(pa);
        check_val("pred_hit", pred_hit, 1);
        do_update(pb, kind_jalr, 1'b1, 32'h0000_b000, h);
        steer_history(h);
        do_lookup(pb);
        check_val("pred_pc", pred_pc, 32'h0000_b000);
        do_lookup(pa);
        check_val("pred_hit", pred_hit, 0);
        check_val("pred_pc", pred_pc, pa + 32'd4);
    endtask

    task automatic random_traffic();
        logic [xlen-1:0]      p;
        logic [xlen-1:0]      target;
        upd_kind_t            kind;
        logic                 taken;
        logic [hist_bits-1:0] h;
        for (int n = 0; n < num_random; n++) begin
            p      = pool[$urandom % pool_size];
            kind   = upd_kind_t'($urandom % 3);
            taken  = 1'($urandom % 2);
            target = $urandom & 32'hffff_fffc;
            // half land where the next lookup of p looks
            h = ($urandom % 2) ? next_history(kind, taken) : hist_bits'($urandom);
            do_update(p, kind, taken, target, h);
            do_lookup(p);
            do_lookup(pool[$urandom % pool_size]);
        end
    endtask

    task automatic idle_keeps_ack_low();
        for (int n = 0; n < 8; n++) begin
            idle_cycles(1 + $urandom % 5);
            do_update(pool[n], kind_jalr, 1'b0, pool[n] + 32'h40, model_hist);
        end
        idle_cycles(3);
        do_lookup(pool[0]);
    endtask

    initial begin
        void'($urandom(32'hacaf4128));
        pc          <= '0;
        upd_req     <= 1'b0;
        upd_pc      <= '0;
        upd_kind    <= kind_cond;
        upd_taken   <= 1'b0;
        upd_target  <= '0;
        upd_history <= '0;
        for (int i = 0; i < entries; i++) begin
            model_valid[i] = 1'b0;
        end
        model_hist = '0;
        foreach (pool[i]) pool[i] = $urandom & 32'hffff_fffc;
        wait (reset === 1'b0);
        @(negedge clk);
        reset_state_misses();
        jal_allocates();
        counter_hysteresis();
        tag_conflict_replaces();
        random_traffic();
        idle_keeps_ack_low();
        if (branch_predictor_inst.asserts_inst.assert_failed) begin
            report_failure("a handshake assertion failed during the run");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

    // stop at the first concurrent assertion failure
    initial begin
        wait (branch_predictor_inst.asserts_inst.assert_failed === 1'b1);
        report_failure("a handshake assertion failed");
    end

    initial begin
        #(watchdog_ns);
        report_failure("watchdog timeout, the tests did not finish in time");
    end

endmodule

`default_nettype wire

// File: verilog.f
bp_pkg.sv
bp_index_router.sv
bp_bank.sv
bp_pred_select.sv
branch_predictor.sv
tb_clock_gen.sv
branch_predictor_asserts.sv
branch_predictor_tb.sv

// File: Bender.yml
package:
  name: branch_predictor

sources:
  - bp_pkg.sv
  - bp_index_router.sv
  - bp_bank.sv
  - bp_pred_select.sv
  - branch_predictor.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - branch_predictor_asserts.sv
      - branch_predictor_tb.sv
